// File: source/core_macros.svh
// core constants for the reset pc, the trap opcode and the data memory layout
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// first fetch address after reset
`define PC_START     64'h0000_0000_8000_0000

// custom opcode that stops the core
// the low byte of x10 is reported as the trap code
`define TRAP_OPCODE  7'h6b

// data ram size in 64-bit words
`define DMEM_DEPTH   256

// address of data word 0
// loads and stores must fall inside DMEM_DEPTH words from here
`define DMEM_BASE    64'h0000_0000_8000_1000

`endif

// File: source/core_pkg.sv
// shared types and stage-to-stage records for the rv64 subset core
package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  trap_code_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_JAL
  } br_kind_e;

  typedef enum logic [1:0] {
    FETCH_ISSUE,
    FETCH_WAIT,
    FETCH_HALT
  } fetch_state_e;

  typedef struct packed {
    logic  valid;
    xlen_t pc;
    inst_t inst;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    inst_t     inst;
    alu_op_e   alu_op;
    br_kind_e  br_kind;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     sdata;
    xlen_t     imm;
    reg_addr_t rd;
    logic      rd_wen;
    logic      load;
    logic      store;
    logic      trap;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    inst_t     inst;
    xlen_t     result;
    xlen_t     next_pc;
    xlen_t     sdata;
    reg_addr_t rd;
    logic      rd_wen;
    logic      load;
    logic      store;
    logic      trap;
  } ex_mem_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    inst_t     inst;
    xlen_t     rd_wdata;
    xlen_t     next_pc;
    reg_addr_t rd;
    logic      rd_wen;
    logic      trap;
  } mem_wb_t;

  typedef struct packed {
    logic  valid;
    xlen_t next_pc;
  } retire_t;

  typedef struct packed {
    logic      valid;
    xlen_t     pc;
    inst_t     inst;
    logic      wen;
    reg_addr_t wdest;
    xlen_t     wdata;
  } commit_t;

endpackage

// File: source/if_stage.sv
// fetch stage holding the pc and issuing one instruction per retire
`timescale 1ns/100ps
`include "core_macros.svh"

module if_stage (
  input  logic              clock,
  input  logic              reset,
  input  core_pkg::retire_t retire_i,
  output core_pkg::xlen_t   imem_addr_o,
  input  core_pkg::inst_t   imem_inst_i,
  output core_pkg::if_id_t  fetch_o
);

  core_pkg::fetch_state_e state_q;
  core_pkg::xlen_t        pc_q;
  core_pkg::xlen_t        fetch_pc;
  logic                   resume;
  logic                   issue;
  logic                   is_trap;

  // retire pulse reopens issue in the same cycle
  assign resume   = (state_q == core_pkg::FETCH_WAIT) && retire_i.valid;
  assign issue    = (state_q == core_pkg::FETCH_ISSUE) || resume;
  assign fetch_pc = resume ? retire_i.next_pc : pc_q;
  assign is_trap  = (imem_inst_i[6:0] == `TRAP_OPCODE);

  assign imem_addr_o = fetch_pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= core_pkg::FETCH_ISSUE;
      pc_q    <= `PC_START;
    end else if (issue) begin
      // nothing follows a trap down the pipe
      state_q <= is_trap ? core_pkg::FETCH_HALT : core_pkg::FETCH_WAIT;
      pc_q    <= fetch_pc;
    end
  end

  always_ff @(posedge clock) begin
    fetch_o.pc   <= fetch_pc;
    fetch_o.inst <= imem_inst_i;
    if (reset) begin
      fetch_o.valid <= 1'b0;
    end else begin
      fetch_o.valid <= issue;
    end
  end

  // a retire only comes back for the one instruction in flight
  // so it never meets a fresh fetch or an idle fetch unit
  assert property (@(posedge clock) disable iff (reset)
    retire_i.valid |-> (state_q != core_pkg::FETCH_ISSUE) && !fetch_o.valid);

endmodule

// File: source/id_stage.sv
// decode stage turning an instruction into operands and control for execute
`timescale 1ns/100ps
`include "core_macros.svh"

module id_stage (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::if_id_t    fetch_i,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  input  core_pkg::xlen_t     rs1_data_i,
  input  core_pkg::xlen_t     rs2_data_i,
  output core_pkg::id_ex_t    decode_o
);

  core_pkg::inst_t  inst;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  core_pkg::xlen_t  imm_i;
  core_pkg::xlen_t  imm_s;
  core_pkg::xlen_t  imm_b;
  core_pkg::xlen_t  imm_u;
  core_pkg::xlen_t  imm_j;
  core_pkg::id_ex_t dec;

  assign inst   = fetch_i.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign rs1_addr_o = inst[19:15];
  assign rs2_addr_o = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec       = '0;
    dec.valid = fetch_i.valid;
    dec.pc    = fetch_i.pc;
    dec.inst  = inst;
    dec.op1   = rs1_data_i;
    dec.op2   = rs2_data_i;
    dec.sdata = rs2_data_i;
    dec.rd    = inst[11:7];
    // unknown encodings fall through as a no-op
    case (opcode)
      7'b0010011: begin
        dec.op2    = imm_i;
        dec.rd_wen = (funct3 == 3'b000);
      end
      7'b0110011: begin
        dec.rd_wen = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
        case (funct3)
          3'b000:  dec.alu_op = (funct7 == 7'h20) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          3'b010:  dec.alu_op = core_pkg::ALU_SLT;
          3'b100:  dec.alu_op = core_pkg::ALU_XOR;
          3'b110:  dec.alu_op = core_pkg::ALU_OR;
          3'b111:  dec.alu_op = core_pkg::ALU_AND;
          default: dec.rd_wen = 1'b0;
        endcase
      end
      7'b0110111: begin
        dec.alu_op = core_pkg::ALU_PASS_B;
        dec.op2    = imm_u;
        dec.rd_wen = 1'b1;
      end
      7'b0000011: begin
        dec.op2    = imm_i;
        dec.load   = (funct3 == 3'b011);
        dec.rd_wen = (funct3 == 3'b011);
      end
      7'b0100011: begin
        dec.op2   = imm_s;
        dec.store = (funct3 == 3'b011);
      end
      7'b1100011: begin
        dec.imm = imm_b;
        if (funct3 == 3'b000) begin
          dec.br_kind = core_pkg::BR_EQ;
        end else if (funct3 == 3'b001) begin
          dec.br_kind = core_pkg::BR_NE;
        end
      end
      7'b1101111: begin
        dec.imm     = imm_j;
        dec.br_kind = core_pkg::BR_JAL;
        dec.rd_wen  = 1'b1;
      end
      `TRAP_OPCODE: dec.trap = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clock) begin
    decode_o <= dec;
    if (reset) begin
      decode_o.valid <= 1'b0;
    end
  end

endmodule

// File: source/exe_stage.sv
// execute stage with the alu, branch compare and next pc select
`timescale 1ns/100ps

module exe_stage (
  input  logic               clock,
  input  logic               reset,
  input  core_pkg::id_ex_t   decode_i,
  output core_pkg::ex_mem_t  exec_o
);

  core_pkg::xlen_t   alu_res;
  core_pkg::xlen_t   pc_plus4;
  core_pkg::xlen_t   target;
  logic              taken;
  core_pkg::ex_mem_t ex;

  always_comb begin
    case (decode_i.alu_op)
      core_pkg::ALU_ADD:    alu_res = decode_i.op1 + decode_i.op2;
      core_pkg::ALU_SUB:    alu_res = decode_i.op1 - decode_i.op2;
      core_pkg::ALU_AND:    alu_res = decode_i.op1 & decode_i.op2;
      core_pkg::ALU_OR:     alu_res = decode_i.op1 | decode_i.op2;
      core_pkg::ALU_XOR:    alu_res = decode_i.op1 ^ decode_i.op2;
      core_pkg::ALU_SLT:    alu_res = {63'b0, $signed(decode_i.op1) < $signed(decode_i.op2)};
      core_pkg::ALU_PASS_B: alu_res = decode_i.op2;
      default:              alu_res = '0;
    endcase
  end

  assign pc_plus4 = decode_i.pc + 64'd4;
  assign target   = decode_i.pc + decode_i.imm;

  always_comb begin
    case (decode_i.br_kind)
      core_pkg::BR_EQ:  taken = (decode_i.op1 == decode_i.op2);
      core_pkg::BR_NE:  taken = (decode_i.op1 != decode_i.op2);
      core_pkg::BR_JAL: taken = 1'b1;
      default:          taken = 1'b0;
    endcase
  end

  always_comb begin
    ex.valid   = decode_i.valid;
    ex.pc      = decode_i.pc;
    ex.inst    = decode_i.inst;
    // jal links pc+4, loads and stores carry the address
    ex.result  = (decode_i.br_kind == core_pkg::BR_JAL) ? pc_plus4 : alu_res;
    ex.next_pc = taken ? target : pc_plus4;
    ex.sdata   = decode_i.sdata;
    ex.rd      = decode_i.rd;
    ex.rd_wen  = decode_i.rd_wen;
    ex.load    = decode_i.load;
    ex.store   = decode_i.store;
    ex.trap    = decode_i.trap;
  end

  always_ff @(posedge clock) begin
    exec_o <= ex;
    if (reset) begin
      exec_o.valid <= 1'b0;
    end
  end

endmodule

// File: source/mem_stage.sv
// memory stage holding the data ram for 64-bit loads and stores
`timescale 1ns/100ps
`include "core_macros.svh"

module mem_stage (
  input  logic               clock,
  input  logic               reset,
  input  core_pkg::ex_mem_t  exec_i,
  output core_pkg::mem_wb_t  mem_o
);

  localparam int IDX_W = $clog2(`DMEM_DEPTH);

  core_pkg::xlen_t   ram [`DMEM_DEPTH];
  core_pkg::xlen_t   offset;
  logic [IDX_W-1:0]  idx;
  core_pkg::mem_wb_t wb;

  assign offset = exec_i.result - `DMEM_BASE;
  assign idx    = offset[IDX_W+2:3];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `DMEM_DEPTH; i++) begin
        ram[i] <= '0;
      end
    end else if (exec_i.valid && exec_i.store) begin
      ram[idx] <= exec_i.sdata;
    end
  end

  always_comb begin
    wb.valid    = exec_i.valid;
    wb.pc       = exec_i.pc;
    wb.inst     = exec_i.inst;
    wb.rd_wdata = exec_i.load ? ram[idx] : exec_i.result;
    wb.next_pc  = exec_i.next_pc;
    wb.rd       = exec_i.rd;
    wb.rd_wen   = exec_i.rd_wen;
    wb.trap     = exec_i.trap;
  end

  always_ff @(posedge clock) begin
    mem_o <= wb;
    if (reset) begin
      mem_o.valid <= 1'b0;
    end
  end

  // addresses computed in execute must name a whole word of the ram
  assert property (@(posedge clock) disable iff (reset)
    exec_i.valid && (exec_i.load || exec_i.store) |-> exec_i.result[2:0] == 3'b000);
  assert property (@(posedge clock) disable iff (reset)
    exec_i.valid && (exec_i.load || exec_i.store) |-> offset < `DMEM_DEPTH * 8);

endmodule

// File: source/wb_stage.sv
// writeback stage driving the register write, commit record and trap event
`timescale 1ns/100ps

module wb_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  core_pkg::mem_wb_t    mem_i,
  output logic                 rd_wen_o,
  output core_pkg::reg_addr_t  rd_addr_o,
  output core_pkg::xlen_t      rd_wdata_o,
  input  core_pkg::xlen_t      x10_i,
  output core_pkg::retire_t    retire_o,
  output core_pkg::commit_t    commit_o,
  output logic                 trap_valid_o,
  output core_pkg::trap_code_t trap_code_o
);

  assign rd_wen_o   = mem_i.valid && mem_i.rd_wen;
  assign rd_addr_o  = mem_i.rd;
  assign rd_wdata_o = mem_i.rd_wdata;

  always_ff @(posedge clock) begin
    commit_o.pc      <= mem_i.pc;
    commit_o.inst    <= mem_i.inst;
    commit_o.wen     <= mem_i.rd_wen && (mem_i.rd != 5'd0);
    commit_o.wdest   <= mem_i.rd;
    commit_o.wdata   <= mem_i.rd_wdata;
    retire_o.next_pc <= mem_i.next_pc;
    if (reset) begin
      commit_o.valid <= 1'b0;
      retire_o.valid <= 1'b0;
      trap_valid_o   <= 1'b0;
      trap_code_o    <= '0;
    end else begin
      commit_o.valid <= mem_i.valid;
      retire_o.valid <= mem_i.valid;
      // trap event stays latched until reset
      if (mem_i.valid && mem_i.trap && !trap_valid_o) begin
        trap_valid_o <= 1'b1;
        trap_code_o  <= x10_i[7:0];
      end
    end
  end

  // fetch halts on the trap, so its commit is the last one
  assert property (@(posedge clock) disable iff (reset)
    trap_valid_o |=> !commit_o.valid);

endmodule

// File: source/regfile.sv
// integer register file with 32 x 64-bit entries and x0 tied to zero
`timescale 1ns/100ps

module regfile (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t rs1_addr_i,
  input  core_pkg::reg_addr_t rs2_addr_i,
  output core_pkg::xlen_t     rs1_data_o,
  output core_pkg::xlen_t     rs2_data_o,
  input  logic                wen_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::xlen_t     wdata_i,
  output core_pkg::xlen_t     x10_o
);

  core_pkg::xlen_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (waddr_i != 5'd0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

  // a0 feeds the trap code
  assign x10_o = regs[10];

endmodule

// File: source/sim_top.sv
// core top level wiring the five stages and the register file
`timescale 1ns/100ps

module sim_top (
  input  logic                 clock,
  input  logic                 reset,
  output core_pkg::xlen_t      imem_addr_o,
  input  core_pkg::inst_t      imem_inst_i,
  output core_pkg::commit_t    commit_o,
  output logic                 trap_valid_o,
  output core_pkg::trap_code_t trap_code_o
);

  core_pkg::if_id_t    fetch;
  core_pkg::id_ex_t    decode;
  core_pkg::ex_mem_t   exec;
  core_pkg::mem_wb_t   mem;
  core_pkg::retire_t   retire;

  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::xlen_t     rs1_data;
  core_pkg::xlen_t     rs2_data;
  logic                rd_wen;
  core_pkg::reg_addr_t rd_addr;
  core_pkg::xlen_t     rd_wdata;
  core_pkg::xlen_t     x10;

  if_stage u_if_stage (
    .clock        (clock        ),
    .reset        (reset        ),
    .retire_i     (retire       ),
    .imem_addr_o  (imem_addr_o  ),
    .imem_inst_i  (imem_inst_i  ),
    .fetch_o      (fetch        )
  );

  id_stage u_id_stage (
    .clock        (clock        ),
    .reset        (reset        ),
    .fetch_i      (fetch        ),
    .rs1_addr_o   (rs1_addr     ),
    .rs2_addr_o   (rs2_addr     ),
    .rs1_data_i   (rs1_data     ),
    .rs2_data_i   (rs2_data     ),
    .decode_o     (decode       )
  );

  exe_stage u_exe_stage (
    .clock        (clock        ),
    .reset        (reset        ),
    .decode_i     (decode       ),
    .exec_o       (exec         )
  );

  mem_stage u_mem_stage (
    .clock        (clock        ),
    .reset        (reset        ),
    .exec_i       (exec         ),
    .mem_o        (mem          )
  );

  wb_stage u_wb_stage (
    .clock        (clock        ),
    .reset        (reset        ),
    .mem_i        (mem          ),
    .rd_wen_o     (rd_wen       ),
    .rd_addr_o    (rd_addr      ),
    .rd_wdata_o   (rd_wdata     ),
    .x10_i        (x10          ),
    .retire_o     (retire       ),
    .commit_o     (commit_o     ),
    .trap_valid_o (trap_valid_o ),
    .trap_code_o  (trap_code_o  )
  );

  regfile u_regfile (
    .clock        (clock        ),
    .reset        (reset        ),
    .rs1_addr_i   (rs1_addr     ),
    .rs2_addr_i   (rs2_addr     ),
    .rs1_data_o   (rs1_data     ),
    .rs2_data_o   (rs2_data     ),
    .wen_i        (rd_wen       ),
    .waddr_i      (rd_addr      ),
    .wdata_i      (rd_wdata     ),
    .x10_o        (x10          )
  );

endmodule

// File: tb/tb_ref_model.sv
// isa reference model that follows the commits and checks them and the trap event
`timescale 1ns/100ps
`include "core_macros.svh"

module tb_ref_model (
  input  logic                 clock,
  input  logic                 reset,
  input  core_pkg::commit_t    commit_i,
  input  logic                 trap_valid_i,
  input  core_pkg::trap_code_t trap_code_i,
  output core_pkg::xlen_t      pc_o,
  input  core_pkg::inst_t      inst_i,
  output logic                 done_o,
  output logic                 error_o
);

  core_pkg::xlen_t     regs [32];
  core_pkg::xlen_t     dmem [`DMEM_DEPTH];
  core_pkg::xlen_t     pc_q;
  logic                halted_q;
  logic                seen_commit_q;
  logic                in_reset_q = 1'b0;
  int unsigned         gap_q;
  logic                mismatch = 1'b0;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  core_pkg::reg_addr_t rd;
  core_pkg::xlen_t     src1;
  core_pkg::xlen_t     src2;
  core_pkg::xlen_t     imm_i;
  core_pkg::xlen_t     imm_s;
  core_pkg::xlen_t     imm_b;
  core_pkg::xlen_t     imm_u;
  core_pkg::xlen_t     imm_j;
  core_pkg::xlen_t     st_addr;
  core_pkg::xlen_t     exp_wdata;
  core_pkg::xlen_t     exp_next;
  logic                exp_wen;
  logic                exp_store;
  logic                exp_trap;
  core_pkg::trap_code_t exp_code;

  assign pc_o    = pc_q;
  assign done_o  = halted_q;
  assign error_o = mismatch;

  function automatic int unsigned word_index(core_pkg::xlen_t addr);
    core_pkg::xlen_t off;
    off = (addr - `DMEM_BASE) >> 3;
    return off[31:0] % `DMEM_DEPTH;
  endfunction

  task automatic report_mismatch(string msg);
    $display("Error %0t: %s", $time, msg);
    mismatch = 1'b1;
  endtask

  // expected effect of the instruction at the model pc
  always_comb begin
    opcode    = inst_i[6:0];
    funct3    = inst_i[14:12];
    funct7    = inst_i[31:25];
    rd        = inst_i[11:7];
    src1      = regs[inst_i[19:15]];
    src2      = regs[inst_i[24:20]];
    imm_i     = {{52{inst_i[31]}}, inst_i[31:20]};
    imm_s     = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    imm_b     = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    imm_u     = {{32{inst_i[31]}}, inst_i[31:12], 12'h000};
    imm_j     = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    st_addr   = src1 + imm_s;
    exp_wen   = 1'b0;
    exp_store = 1'b0;
    exp_trap  = 1'b0;
    exp_wdata = '0;
    exp_next  = pc_q + 64'd4;
    exp_code  = regs[10][7:0];
    case (opcode)
      7'h13: begin
        exp_wen   = (funct3 == 3'b000);
        exp_wdata = src1 + imm_i;
      end
      7'h33: begin
        exp_wen = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: exp_wdata = src1 + src2;
          {7'h20, 3'b000}: exp_wdata = src1 - src2;
          {7'h00, 3'b111}: exp_wdata = src1 & src2;
          {7'h00, 3'b110}: exp_wdata = src1 | src2;
          {7'h00, 3'b100}: exp_wdata = src1 ^ src2;
          {7'h00, 3'b010}: exp_wdata = ($signed(src1) < $signed(src2)) ? 64'd1 : 64'd0;
          default:         exp_wen = 1'b0;
        endcase
      end
      7'h37: begin
        exp_wen   = 1'b1;
        exp_wdata = imm_u;
      end
      7'h03: begin
        exp_wen   = (funct3 == 3'b011);
        exp_wdata = dmem[word_index(src1 + imm_i)];
      end
      7'h23: exp_store = (funct3 == 3'b011);
      7'h63: begin
        if ((funct3 == 3'b000 && src1 == src2) || (funct3 == 3'b001 && src1 != src2)) begin
          exp_next = pc_q + imm_b;
        end
      end
      7'h6f: begin
        exp_wen   = 1'b1;
        exp_wdata = pc_q + 64'd4;
        exp_next  = pc_q + imm_j;
      end
      `TRAP_OPCODE: exp_trap = 1'b1;
      default: ;
    endcase
    if (rd == 5'd0) begin
      exp_wen = 1'b0;
    end
  end

  always @(posedge clock) begin
    in_reset_q <= reset;
    if (reset) begin
      pc_q          <= `PC_START;
      halted_q      <= 1'b0;
      seen_commit_q <= 1'b0;
      gap_q         <= 0;
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      for (int i = 0; i < `DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (commit_i.valid) begin
      gap_q         <= 1;
      seen_commit_q <= 1'b1;
      pc_q          <= exp_next;
      if (exp_wen) begin
        regs[rd] <= exp_wdata;
      end
      if (exp_store) begin
        dmem[word_index(st_addr)] <= src2;
      end
      if (exp_trap) begin
        halted_q <= 1'b1;
      end
    end else begin
      gap_q <= gap_q + 1;
    end
  end

  reset_quiet_a: assert property (@(posedge clock)
    in_reset_q |-> !commit_i.valid && !trap_valid_i)
    else report_mismatch("commit or trap active during reset or right after it");

  commit_pc_a: assert property (@(posedge clock) disable iff (reset)
    commit_i.valid |-> commit_i.pc == pc_q)
    else report_mismatch($sformatf("commit pc %h, expected %h", commit_i.pc, pc_q));

  commit_inst_a: assert property (@(posedge clock) disable iff (reset)
    commit_i.valid |-> commit_i.inst == inst_i)
    else report_mismatch($sformatf("commit inst %h, expected %h", commit_i.inst, inst_i));

  commit_wen_a: assert property (@(posedge clock) disable iff (reset)
    commit_i.valid |-> commit_i.wen == exp_wen)
    else report_mismatch($sformatf("commit wen %b, expected %b", commit_i.wen, exp_wen));

  commit_data_a: assert property (@(posedge clock) disable iff (reset)
    commit_i.valid && exp_wen |-> commit_i.wdest == rd && commit_i.wdata == exp_wdata)
    else report_mismatch($sformatf("write x%0d = %h, expected x%0d = %h",
                                   commit_i.wdest, commit_i.wdata, rd, exp_wdata));

  // one instruction in flight, so retire to retire is fixed
  commit_gap_a: assert property (@(posedge clock) disable iff (reset)
    commit_i.valid && seen_commit_q |-> gap_q == 5)
    else report_mismatch($sformatf("commit gap %0d cycles, expected 5", gap_q));

  trap_event_a: assert property (@(posedge clock) disable iff (reset)
    commit_i.valid && exp_trap |-> trap_valid_i && trap_code_i == exp_code)
    else report_mismatch($sformatf("trap valid %b code %h, expected 1 and %h",
                                   trap_valid_i, trap_code_i, exp_code));

  trap_early_a: assert property (@(posedge clock) disable iff (reset)
    !halted_q && !(commit_i.valid && exp_trap) |-> !trap_valid_i)
    else report_mismatch("trap raised before the trap instruction committed");

  trap_final_a: assert property (@(posedge clock) disable iff (reset)
    halted_q |-> trap_valid_i && !commit_i.valid)
    else report_mismatch("commit after the trap or trap event dropped");

endmodule

// File: tb/tb_sim_top.sv
// testbench for the core with a program rom, a reference model checker and a run timeout
`timescale 1ns/100ps
`include "core_macros.svh"

module tb_sim_top;

  localparam int PROG_LEN  = 29;
  localparam int ROM_AW    = $clog2(PROG_LEN);
  localparam int RESET_CYC = 16;
  localparam int CYC_LIMIT = PROG_LEN * 5 + RESET_CYC + 50;

  logic                 clock;
  logic                 reset;
  core_pkg::xlen_t      imem_addr;
  core_pkg::inst_t      imem_inst;
  core_pkg::commit_t    commit;
  logic                 trap_valid;
  core_pkg::trap_code_t trap_code;
  core_pkg::xlen_t      model_pc;
  core_pkg::inst_t      model_inst;
  logic                 model_done;
  logic                 model_error;

  core_pkg::inst_t rom [PROG_LEN];
  int              seed = 52110;
  int              cycles;

  function automatic core_pkg::inst_t r_type(logic [6:0] f7, core_pkg::reg_addr_t rs2,
                                              core_pkg::reg_addr_t rs1, logic [2:0] f3,
                                              core_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic core_pkg::inst_t i_type(logic [11:0] imm, core_pkg::reg_addr_t rs1,
                                              logic [2:0] f3, core_pkg::reg_addr_t rd,
                                              logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic core_pkg::inst_t s_type(logic [11:0] off, core_pkg::reg_addr_t rs2,
                                              core_pkg::reg_addr_t rs1);
    return {off[11:5], rs2, rs1, 3'b011, off[4:0], 7'h23};
  endfunction

  function automatic core_pkg::inst_t b_type(logic [12:0] off, core_pkg::reg_addr_t rs2,
                                              core_pkg::reg_addr_t rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic core_pkg::inst_t u_type(logic [19:0] imm, core_pkg::reg_addr_t rd);
    return {imm, rd, 7'h37};
  endfunction

  function automatic core_pkg::inst_t j_type(logic [20:0] off, core_pkg::reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  // addresses outside the program read as addi x0, x0, 0
  function automatic core_pkg::inst_t rom_read(core_pkg::xlen_t addr);
    core_pkg::xlen_t word;
    word = (addr - `PC_START) >> 2;
    if (addr < `PC_START || word >= PROG_LEN) begin
      return 32'h0000_0013;
    end
    return rom[word[ROM_AW-1:0]];
  endfunction

  task automatic load_program();
    int          r;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [11:0] imm_c;
    logic [11:0] off_a;
    logic [11:0] off_b;
    logic [11:0] off_c;
    r = $random(seed);
    imm_a = r[11:0];
    r = $random(seed);
    imm_b = r[11:0];
    r = $random(seed);
    imm_c = r[11:0];
    // three disjoint word ranges, the third one is never stored to
    r = $random(seed);
    off_a = {3'b000, r[5:0], 3'b000};
    r = $random(seed);
    off_b = {3'b001, r[5:0], 3'b000};
    r = $random(seed);
    off_c = {2'b01, r[6:0], 3'b000};
    // x5 = data base, built from sign-extended lui values
    rom[0]  = u_type(20'h80001, 5'd5);
    rom[1]  = u_type(20'h80000, 5'd6);
    rom[2]  = r_type(7'h00, 5'd6, 5'd6, 3'b000, 5'd6);
    rom[3]  = r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd5);
    rom[4]  = i_type(imm_a, 5'd0, 3'b000, 5'd1, 7'h13);
    rom[5]  = i_type(imm_b, 5'd0, 3'b000, 5'd2, 7'h13);
    rom[6]  = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    rom[7]  = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
    rom[8]  = r_type(7'h00, 5'd4, 5'd3, 3'b111, 5'd7);
    rom[9]  = r_type(7'h00, 5'd4, 5'd3, 3'b110, 5'd8);
    rom[10] = r_type(7'h00, 5'd3, 5'd1, 3'b100, 5'd9);
    rom[11] = r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd11);
    rom[12] = s_type(off_a, 5'd3, 5'd5);
    rom[13] = s_type(off_b, 5'd4, 5'd5);
    rom[14] = i_type(off_a, 5'd5, 3'b011, 5'd12, 7'h03);
    rom[15] = i_type(off_b, 5'd5, 3'b011, 5'd13, 7'h03);
    rom[16] = i_type(off_c, 5'd5, 3'b011, 5'd14, 7'h03);
    // taken beq, untaken bne, taken bne, untaken beq, jal
    rom[17] = b_type(13'd8, 5'd3, 5'd12, 3'b000);
    rom[18] = i_type(12'd1, 5'd0, 3'b000, 5'd15, 7'h13);
    rom[19] = b_type(13'd8, 5'd3, 5'd12, 3'b001);
    rom[20] = i_type(imm_c, 5'd0, 3'b000, 5'd16, 7'h13);
    rom[21] = b_type(13'd8, 5'd0, 5'd5, 3'b001);
    rom[22] = i_type(12'd2, 5'd0, 3'b000, 5'd17, 7'h13);
    rom[23] = b_type(13'd8, 5'd6, 5'd14, 3'b000);
    rom[24] = j_type(21'd8, 5'd18);
    rom[25] = i_type(12'd3, 5'd0, 3'b000, 5'd19, 7'h13);
    rom[26] = i_type(12'd5, 5'd1, 3'b000, 5'd0, 7'h13);
    rom[27] = r_type(7'h00, 5'd16, 5'd9, 3'b000, 5'd10);
    rom[28] = {25'd0, `TRAP_OPCODE};
  endtask

  task automatic end_with_failure(string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  always_comb imem_inst = rom_read(imem_addr);
  always_comb model_inst = rom_read(model_pc);

  sim_top DUT (
    .clock        (clock      ),
    .reset        (reset      ),
    .imem_addr_o  (imem_addr  ),
    .imem_inst_i  (imem_inst  ),
    .commit_o     (commit     ),
    .trap_valid_o (trap_valid ),
    .trap_code_o  (trap_code  )
  );

  tb_ref_model u_ref_model (
    .clock        (clock       ),
    .reset        (reset       ),
    .commit_i     (commit      ),
    .trap_valid_i (trap_valid  ),
    .trap_code_i  (trap_code   ),
    .pc_o         (model_pc    ),
    .inst_i       (model_inst  ),
    .done_o       (model_done  ),
    .error_o      (model_error )
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin : watch_errors
    @(posedge model_error);
    end_with_failure("reference model reported a mismatch");
  end

  initial begin : run
    reset = 1'b1;
    load_program();
    repeat (RESET_CYC) @(posedge clock);
    reset <= 1'b0;
    cycles = RESET_CYC;
    while (!model_done && cycles < CYC_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (!model_done) begin
      end_with_failure($sformatf("the core did not reach the trap within %0d cycles", cycles));
    end else begin
      // a few more cycles so that no late commit goes unnoticed
      repeat (8) @(negedge clock);
      if (model_error) begin
        end_with_failure("reference model reported a mismatch");
      end else begin
        $display("Simulation finished: PASS");
        $finish;
      end
    end
  end

endmodule

// File: all.f
+incdir+source
source/core_pkg.sv
source/if_stage.sv
source/id_stage.sv
source/exe_stage.sv
source/mem_stage.sv
source/wb_stage.sv
source/regfile.sv
source/sim_top.sv
tb/tb_ref_model.sv
tb/tb_sim_top.sv

// File: Makefile
# Verilator build and run of the core testbench

SIM         ?= verilator
TOP         ?= tb_sim_top
FILELIST    ?= all.f
OBJ_DIR     ?= obj_dir
EXTRA_FLAGS ?=
PASS_MSG    := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: SIM TOP FILELIST OBJ_DIR EXTRA_FLAGS"

test:
	$(SIM) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
	  -Mdir $(OBJ_DIR) $(EXTRA_FLAGS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
